// File: filelist.f
hdl/jtag_pkg.sv
hdl/tap_fsm.sv
hdl/tap_instr_reg.sv
hdl/tap_data_path.sv
hdl/jtag_tap_top.sv
tests/tb_clock_gen.sv
tests/jtag_tap_props.sv
tests/tb_jtag_tap.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the TAP testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_jtag_tap -f filelist.f \
	&& ./obj_dir/Vtb_jtag_tap | tee sim.log \
	|| { echo "build or run error"; exit 1; }
grep -qx "TESTS PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: tests/tb_jtag_tap.sv
// JTAG TAP controller testbench
`timescale 1ns/1ps

module tb_jtag_tap;

	localparam jtag_pkg::idcode_t IDCODE_VALUE = 32'h4BA0_0477;

	// Cycle count of each test as driven below
	localparam int CYC_RESET  = 10 + 36;
	localparam int CYC_WALK   = 400;
	localparam int CYC_IDCODE = 7 + 38;
	localparam int CYC_INSTR  = 8 * 11;
	localparam int CYC_BYPASS = 11 + 22;
	localparam int CYC_CHAIN  = 4 * (11 + 18);
	localparam int CYCLE_BUDGET = CYC_RESET + CYC_WALK + CYC_IDCODE + CYC_INSTR
		+ CYC_BYPASS + CYC_CHAIN + 200;

	logic dif;
	logic test_logic_reset;
	logic tms_i;
	logic tdi_i;
	jtag_pkg::chain_tdo_t chain_tdo_i;
	logic tdo_o;
	logic tdo_oe_o;
	jtag_pkg::dr_select_t select_o;
	logic logic_reset_o, run_test_idle_o, capture_dr_o;
	logic shift_dr_o, pause_dr_o, update_dr_o;

	// Model state
	jtag_pkg::tap_state_e m_state;
	jtag_pkg::ir_t        m_ir;
	jtag_pkg::ir_t        m_lat;
	jtag_pkg::idcode_t    m_id;
	logic                 m_byp, m_tdo, m_oe;

	logic [31:0] lfsr = 32'h88e8;
	// TDO bits seen while enabled with the newest at the MSB
	logic [31:0] cap;
	int cap_n, errors, checks, tests, test_err;
	string cur_test;

	tb_clock_gen u_clk (.dif(dif), .test_logic_reset(test_logic_reset));

	jtag_tap_top #(.IDCODE_VALUE(IDCODE_VALUE)) u_dut
	(
		.dif(dif), .test_logic_reset(test_logic_reset), .tms_i(tms_i), .tdi_i(tdi_i),
		.chain_tdo_i(chain_tdo_i), .tdo_o(tdo_o), .tdo_oe_o(tdo_oe_o), .select_o(select_o),
		.logic_reset_o(logic_reset_o), .run_test_idle_o(run_test_idle_o),
		.capture_dr_o(capture_dr_o), .shift_dr_o(shift_dr_o),
		.pause_dr_o(pause_dr_o), .update_dr_o(update_dr_o)
	);

	////////////////////////////////////////
	// Random bits and reference rules
	////////////////////////////////////////

	// Galois LFSR stepped once per bit
	function automatic logic rand_bit();
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		return lfsr[0];
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v[i] = rand_bit();
		return v;
	endfunction

	// IEEE 1149.1 transition table
	function automatic jtag_pkg::tap_state_e next_state(jtag_pkg::tap_state_e s, logic t);
		case (s)
			jtag_pkg::ST_TLR:      return t ? jtag_pkg::ST_TLR : jtag_pkg::ST_RTI;
			jtag_pkg::ST_RTI:      return t ? jtag_pkg::ST_SEL_DR : jtag_pkg::ST_RTI;
			jtag_pkg::ST_SEL_DR:   return t ? jtag_pkg::ST_SEL_IR : jtag_pkg::ST_CAP_DR;
			jtag_pkg::ST_CAP_DR:   return t ? jtag_pkg::ST_EXIT1_DR : jtag_pkg::ST_SHIFT_DR;
			jtag_pkg::ST_SHIFT_DR: return t ? jtag_pkg::ST_EXIT1_DR : jtag_pkg::ST_SHIFT_DR;
			jtag_pkg::ST_EXIT1_DR: return t ? jtag_pkg::ST_UPD_DR : jtag_pkg::ST_PAUSE_DR;
			jtag_pkg::ST_PAUSE_DR: return t ? jtag_pkg::ST_EXIT2_DR : jtag_pkg::ST_PAUSE_DR;
			jtag_pkg::ST_EXIT2_DR: return t ? jtag_pkg::ST_UPD_DR : jtag_pkg::ST_SHIFT_DR;
			jtag_pkg::ST_UPD_DR:   return t ? jtag_pkg::ST_SEL_DR : jtag_pkg::ST_RTI;
			jtag_pkg::ST_SEL_IR:   return t ? jtag_pkg::ST_TLR : jtag_pkg::ST_CAP_IR;
			jtag_pkg::ST_CAP_IR:   return t ? jtag_pkg::ST_EXIT1_IR : jtag_pkg::ST_SHIFT_IR;
			jtag_pkg::ST_SHIFT_IR: return t ? jtag_pkg::ST_EXIT1_IR : jtag_pkg::ST_SHIFT_IR;
			jtag_pkg::ST_EXIT1_IR: return t ? jtag_pkg::ST_UPD_IR : jtag_pkg::ST_PAUSE_IR;
			jtag_pkg::ST_PAUSE_IR: return t ? jtag_pkg::ST_EXIT2_IR : jtag_pkg::ST_PAUSE_IR;
			jtag_pkg::ST_EXIT2_IR: return t ? jtag_pkg::ST_UPD_IR : jtag_pkg::ST_SHIFT_IR;
			default:               return t ? jtag_pkg::ST_SEL_DR : jtag_pkg::ST_RTI;
		endcase
	endfunction

	// Unknown opcodes fall to bypass
	function automatic jtag_pkg::dr_select_t decode(jtag_pkg::ir_t op);
		case (op)
			jtag_pkg::OP_EXTEST:         return 6'b100000;
			jtag_pkg::OP_SAMPLE_PRELOAD: return 6'b010000;
			jtag_pkg::OP_IDCODE:         return 6'b001000;
			jtag_pkg::OP_MBIST:          return 6'b000100;
			jtag_pkg::OP_DEBUG:          return 6'b000010;
			default:                     return 6'b000001;
		endcase
	endfunction

	task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (exp === act)
		else
		begin
			$display("CHECK FAILED %s %s expected %h actual %h", cur_test, what, exp, act);
			errors++;
			test_err++;
		end
	endtask

	// Model reaction to one rising edge
	task automatic advance(input logic tms, input logic tdi, input jtag_pkg::chain_tdo_t ch);
		jtag_pkg::dr_select_t sel;
		logic rst;
		sel = decode(m_lat);
		rst = (m_state == jtag_pkg::ST_TLR);
		if (m_state == jtag_pkg::ST_SHIFT_IR)
			m_tdo = m_ir[0];
		else if (sel.idcode)
			m_tdo = m_id[0];
		else if (sel.extest || sel.sample_preload)
			m_tdo = ch.bs_chain;
		else if (sel.mbist)
			m_tdo = ch.mbist;
		else if (sel.debug)
			m_tdo = ch.debug;
		else
			m_tdo = m_byp;
		m_oe = (m_state == jtag_pkg::ST_SHIFT_IR) || (m_state == jtag_pkg::ST_SHIFT_DR);
		if (rst)
		begin
			m_ir  = '0;
			m_lat = jtag_pkg::OP_IDCODE;
			m_id  = IDCODE_VALUE;
			m_byp = 1'b0;
		end
		else
		begin
			if (m_state == jtag_pkg::ST_CAP_IR)
				m_ir = jtag_pkg::IR_CAPTURE;
			else if (m_state == jtag_pkg::ST_SHIFT_IR)
				m_ir = {tdi, m_ir[3:1]};
			if (m_state == jtag_pkg::ST_UPD_IR)
				m_lat = m_ir;
			if (sel.idcode && m_state == jtag_pkg::ST_CAP_DR)
				m_id = IDCODE_VALUE;
			else if (sel.idcode && m_state == jtag_pkg::ST_SHIFT_DR)
				m_id = {tdi, m_id[31:1]};
			if (sel.bypass && m_state == jtag_pkg::ST_CAP_DR)
				m_byp = 1'b0;
			else if (sel.bypass && m_state == jtag_pkg::ST_SHIFT_DR)
				m_byp = tdi;
		end
		m_state = next_state(m_state, tms);
	endtask

	////////////////////////////////////////
	// One TCK cycle with full compare
	////////////////////////////////////////

	task automatic tick(input logic tms, input logic tdi);
		jtag_pkg::chain_tdo_t ch;
		logic [31:0] r;
		r  = rand_bits(3);
		ch = r[2:0];
		@(posedge dif);
		tms_i       <= tms;
		tdi_i       <= tdi;
		chain_tdo_i <= ch;
		// Sample mid-cycle away from the edge
		@(negedge dif);
		check("strobes", {m_state == jtag_pkg::ST_TLR, m_state == jtag_pkg::ST_RTI,
			m_state == jtag_pkg::ST_CAP_DR, m_state == jtag_pkg::ST_SHIFT_DR,
			m_state == jtag_pkg::ST_PAUSE_DR, m_state == jtag_pkg::ST_UPD_DR},
			{logic_reset_o, run_test_idle_o, capture_dr_o, shift_dr_o, pause_dr_o, update_dr_o});
		check("select_o", decode(m_lat), select_o);
		check("tdo_o", m_tdo, tdo_o);
		check("tdo_oe_o", m_oe, tdo_oe_o);
		if (tdo_oe_o)
		begin
			cap = {tdo_o, cap[31:1]};
			cap_n++;
		end
		advance(tms, tdi, ch);
	endtask

	// Pass through Test-Logic-Reset and end in Run-Test/Idle
	task automatic goto_idle();
		repeat (6) tick(1'b1, 1'b0);
		tick(1'b0, 1'b0);
	endtask

	// IR or DR scan of n bits from Run-Test/Idle back to Run-Test/Idle
	task automatic scan(input logic ir, input int n, input logic [31:0] din);
		cap   = '0;
		cap_n = 0;
		tick(1'b1, 1'b0);
		if (ir)
			tick(1'b1, 1'b0);
		tick(1'b0, 1'b0);
		tick(1'b0, 1'b0);
		for (int i = 0; i < n; i++)
			tick(i == n - 1, din[i]);
		tick(1'b1, 1'b0);
		tick(1'b0, 1'b0);
		tick(1'b0, 1'b0);
	endtask

	task automatic finish_test();
		tests++;
		$display("test %-12s done, %0d errors", cur_test, test_err);
		test_err = 0;
	endtask

	// Watchdog
	initial
	begin
		#(CYCLE_BUDGET * 10);
		$display("Timeout: tests did not finish within %0d cycles", CYCLE_BUDGET);
		$display("TESTS FAILED");
		$finish;
	end

	initial
	begin
		jtag_pkg::ir_t op;
		jtag_pkg::ir_t chain_ops [4];
		logic [31:0] din;
		chain_ops = '{jtag_pkg::OP_EXTEST, jtag_pkg::OP_SAMPLE_PRELOAD,
			jtag_pkg::OP_MBIST, jtag_pkg::OP_DEBUG};
		tms_i       = 1'b1;
		tdi_i       = 1'b0;
		chain_tdo_i = '0;
		errors      = 0;
		checks      = 0;
		tests       = 0;
		test_err    = 0;
		do
			@(negedge dif);
		while (test_logic_reset);
		// DUT now holds reset values
		m_state = jtag_pkg::ST_TLR;
		m_ir    = '0;
		m_lat   = jtag_pkg::OP_IDCODE;
		m_id    = IDCODE_VALUE;
		m_byp   = 1'b0;
		m_tdo   = 1'b0;
		m_oe    = 1'b0;

		cur_test = "reset";
		check("logic_reset_o", 1, logic_reset_o);
		check("tdo_oe_o", 0, tdo_oe_o);
		check("dr strobes", 0, {capture_dr_o, shift_dr_o, pause_dr_o, update_dr_o});
		check("select_o", decode(jtag_pkg::OP_IDCODE), select_o);
		advance(1'b1, 1'b0, '0);
		repeat (30) tick(rand_bit(), rand_bit());
		repeat (6) tick(1'b1, 1'b0);
		check("back to reset", 1, logic_reset_o);
		finish_test();

		cur_test = "state_walk";
		repeat (400) tick(rand_bit(), rand_bit());
		finish_test();

		cur_test = "idcode";
		goto_idle();
		scan(1'b0, 32, rand_bits(32));
		check("bit count", 32, cap_n);
		check("idcode", IDCODE_VALUE, cap);
		finish_test();

		cur_test = "instr_load";
		repeat (8)
		begin
			din = rand_bits(jtag_pkg::IR_W);
			op  = din[jtag_pkg::IR_W-1:0];
			scan(1'b1, 4, op);
			check("capture", jtag_pkg::IR_CAPTURE, cap[31:28]);
			check("decode", decode(op), select_o);
		end
		finish_test();

		cur_test = "bypass";
		scan(1'b1, 4, jtag_pkg::OP_BYPASS);
		din = rand_bits(16);
		scan(1'b0, 16, din);
		check("delayed tdi", {din[14:0], 1'b0}, cap[31:16]);
		finish_test();

		cur_test = "chain_route";
		foreach (chain_ops[i])
		begin
			scan(1'b1, 4, chain_ops[i]);
			scan(1'b0, 12, rand_bits(12));
		end
		finish_test();

		$display("%0d tests, %0d checks, %0d failures", tests, checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: tests/jtag_tap_props.sv
// TAP controller properties
`timescale 1ns/1ps

module jtag_tap_props
(
	input logic                 dif,
	input logic                 test_logic_reset,
	input logic                 tms_i,
	input logic                 shift_dr_o,
	input logic                 shift_ir,
	input logic                 logic_reset_o,
	input logic                 tdo_oe_o,
	input jtag_pkg::dr_select_t select_o
);

	// Exactly one data register selected
	a_select_onehot: assert property (@(posedge dif) disable iff (test_logic_reset)
		$onehot(select_o))
		else $error("data register select is not one-hot");

	// Shifting never happens inside Test-Logic-Reset
	a_shift_not_reset: assert property (@(posedge dif) disable iff (test_logic_reset)
		!((shift_dr_o || shift_ir) && logic_reset_o))
		else $error("shift strobe seen together with reset strobe");

	// Output enable is the shift strobe delayed by one edge
	a_oe_follows_shift: assert property (@(posedge dif) disable iff (test_logic_reset)
		shift_dr_o |=> tdo_oe_o)
		else $error("tdo_oe_o did not follow shift_dr_o");

	////////////////////////////////////////
	// Five TMS-high edges reach reset
	////////////////////////////////////////

	a_tms_reset: assert property (@(posedge dif) disable iff (test_logic_reset)
		(tms_i && $past(tms_i) && $past(tms_i, 2) && $past(tms_i, 3) && $past(tms_i, 4))
		|=> logic_reset_o)
		else $error("five TMS-high cycles did not reach Test-Logic-Reset");

endmodule

// Attached to every instance of the top level
bind jtag_tap_top jtag_tap_props u_props
(
	.dif              (dif),
	.test_logic_reset (test_logic_reset),
	.tms_i            (tms_i),
	.shift_dr_o       (shift_dr_o),
	.shift_ir         (ctrl.shift_ir),
	.logic_reset_o    (logic_reset_o),
	.tdo_oe_o         (tdo_oe_o),
	.select_o         (select_o)
);

// File: tests/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen
#(
	parameter int RESET_CYCLES = 10
)
(
	output logic dif,
	output logic test_logic_reset
);

	// 10 ns period
	initial
	begin
		dif = 1'b0;
		forever #5 dif = ~dif;
	end

	// Reset held high for the first cycles, released on a rising edge
	initial
	begin
		test_logic_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge dif);
		test_logic_reset <= 1'b0;
	end

endmodule

// File: hdl/jtag_tap_top.sv
// JTAG TAP controller top
`timescale 1ns/1ps

module jtag_tap_top
#(
	parameter jtag_pkg::idcode_t IDCODE_VALUE = 32'h1A5C_0F3D
)
(
	input  logic                 dif,
	input  logic                 test_logic_reset,
	input  logic                 tms_i,
	input  logic                 tdi_i,
	input  jtag_pkg::chain_tdo_t chain_tdo_i,
	output logic                 tdo_o,
	output logic                 tdo_oe_o,
	output jtag_pkg::dr_select_t select_o,
	output logic                 logic_reset_o,
	output logic                 run_test_idle_o,
	output logic                 capture_dr_o,
	output logic                 shift_dr_o,
	output logic                 pause_dr_o,
	output logic                 update_dr_o
);

	// Strobes shared by the IR and the data path
	jtag_pkg::tap_ctrl_t ctrl;
	logic                ir_tdo;

	////////////////////////////////////////
	// Stages
	////////////////////////////////////////

	tap_fsm u_fsm
	(
		.dif              (dif),
		.test_logic_reset (test_logic_reset),
		.tms_i            (tms_i),
		.ctrl_o           (ctrl)
	);

	tap_instr_reg u_ir
	(
		.dif              (dif),
		.test_logic_reset (test_logic_reset),
		.tdi_i            (tdi_i),
		.ctrl_i           (ctrl),
		.ir_tdo_o         (ir_tdo),
		.select_o         (select_o)
	);

	tap_data_path #(
		.IDCODE_VALUE (IDCODE_VALUE)
	) u_dp
	(
		.dif              (dif),
		.test_logic_reset (test_logic_reset),
		.tdi_i            (tdi_i),
		.ctrl_i           (ctrl),
		.select_i         (select_o),
		.ir_tdo_i         (ir_tdo),
		.chain_tdo_i      (chain_tdo_i),
		.tdo_o            (tdo_o),
		.tdo_oe_o         (tdo_oe_o)
	);

	// Strobes visible at the boundary
	assign logic_reset_o   = ctrl.in_reset;
	assign run_test_idle_o = ctrl.run_test_idle;
	assign capture_dr_o    = ctrl.capture_dr;
	assign shift_dr_o      = ctrl.shift_dr;
	assign pause_dr_o      = ctrl.pause_dr;
	assign update_dr_o     = ctrl.update_dr;

endmodule

// File: hdl/tap_data_path.sv
// TAP data registers and TDO
`timescale 1ns/1ps

module tap_data_path
#(
	parameter jtag_pkg::idcode_t IDCODE_VALUE = 32'h1A5C_0F3D
)
(
	input  logic                 dif,
	input  logic                 test_logic_reset,
	input  logic                 tdi_i,
	input  jtag_pkg::tap_ctrl_t  ctrl_i,
	input  jtag_pkg::dr_select_t select_i,
	input  logic                 ir_tdo_i,
	input  jtag_pkg::chain_tdo_t chain_tdo_i,
	output logic                 tdo_o,
	output logic                 tdo_oe_o
);

	jtag_pkg::idcode_t idcode_q;
	// Single bit bypass stage
	logic              bypass_q;
	// Combinational TDO source
	logic              tdo_mux;

	////////////////////////////////////////
	// IDCODE register
	////////////////////////////////////////

	// Reloaded in Test-Logic-Reset so the first read is valid
	always_ff @(posedge dif)
	begin
		if (test_logic_reset || ctrl_i.in_reset)
			idcode_q <= IDCODE_VALUE;
		else if (select_i.idcode && ctrl_i.capture_dr)
			idcode_q <= IDCODE_VALUE;
		else if (select_i.idcode && ctrl_i.shift_dr)
			idcode_q <= {tdi_i, idcode_q[31:1]};
	end

	////////////////////////////////////////
	// Bypass register
	////////////////////////////////////////

	always_ff @(posedge dif)
	begin
		if (test_logic_reset || ctrl_i.in_reset)
			bypass_q <= 1'b0;
		else if (select_i.bypass && ctrl_i.capture_dr)
			bypass_q <= 1'b0;
		else if (select_i.bypass && ctrl_i.shift_dr)
			bypass_q <= tdi_i;
	end

	////////////////////////////////////////
	// TDO multiplexer
	////////////////////////////////////////

	// IR takes priority during Shift-IR
	always_comb
	begin
		if (ctrl_i.shift_ir)
			tdo_mux = ir_tdo_i;
		else if (select_i.idcode)
			tdo_mux = idcode_q[0];
		else if (select_i.extest || select_i.sample_preload)
			// Both boundary scan opcodes share one chain
			tdo_mux = chain_tdo_i.bs_chain;
		else if (select_i.mbist)
			tdo_mux = chain_tdo_i.mbist;
		else if (select_i.debug)
			tdo_mux = chain_tdo_i.debug;
		else
			tdo_mux = bypass_q;
	end

	////////////////////////////////////////
	// Output registers
	////////////////////////////////////////

	// Pad outputs lag the producing state by one cycle
	always_ff @(posedge dif)
	begin
		if (test_logic_reset)
		begin
			tdo_o    <= 1'b0;
			tdo_oe_o <= 1'b0;
		end
		else
		begin
			tdo_o    <= tdo_mux;
			tdo_oe_o <= ctrl_i.shift_ir | ctrl_i.shift_dr;
		end
	end

endmodule

// File: hdl/tap_instr_reg.sv
// TAP instruction register
`timescale 1ns/1ps

module tap_instr_reg
(
	input  logic                 dif,
	input  logic                 test_logic_reset,
	input  logic                 tdi_i,
	input  jtag_pkg::tap_ctrl_t  ctrl_i,
	output logic                 ir_tdo_o,
	output jtag_pkg::dr_select_t select_o
);

	// Shift stage and latched instruction
	jtag_pkg::ir_t ir_q;
	jtag_pkg::ir_t latched_q;

	////////////////////////////////////////
	// Shift register
	////////////////////////////////////////

	always_ff @(posedge dif)
	begin
		if (test_logic_reset || ctrl_i.in_reset)
			ir_q <= '0;
		else if (ctrl_i.capture_ir)
			ir_q <= jtag_pkg::IR_CAPTURE;
		else if (ctrl_i.shift_ir)
			// TDI enters at the MSB and the LSB leaves first
			ir_q <= {tdi_i, ir_q[jtag_pkg::IR_W-1:1]};
	end

	// Serial return toward the TDO mux
	assign ir_tdo_o = ir_q[0];

	////////////////////////////////////////
	// Latched instruction
	////////////////////////////////////////

	// IDCODE is the power-on instruction
	always_ff @(posedge dif)
	begin
		if (test_logic_reset || ctrl_i.in_reset)
			latched_q <= jtag_pkg::OP_IDCODE;
		else if (ctrl_i.update_ir)
			latched_q <= ir_q;
	end

	////////////////////////////////////////
	// Data register select
	////////////////////////////////////////

	// Exactly one select bit is set at any time
	always_comb
	begin
		select_o = '0;
		case (latched_q)
			jtag_pkg::OP_EXTEST:         select_o.extest         = 1'b1;
			jtag_pkg::OP_SAMPLE_PRELOAD: select_o.sample_preload = 1'b1;
			jtag_pkg::OP_IDCODE:         select_o.idcode         = 1'b1;
			jtag_pkg::OP_MBIST:          select_o.mbist          = 1'b1;
			jtag_pkg::OP_DEBUG:          select_o.debug          = 1'b1;
			jtag_pkg::OP_BYPASS:         select_o.bypass         = 1'b1;
			// Unassigned opcodes act as BYPASS
			default:                     select_o.bypass         = 1'b1;
		endcase
	end

endmodule

// File: hdl/tap_fsm.sv
// TAP state machine
`timescale 1ns/1ps

module tap_fsm
(
	input  logic                dif,
	input  logic                test_logic_reset,
	input  logic                tms_i,
	output jtag_pkg::tap_ctrl_t ctrl_o
);

	// Current and next TAP state
	jtag_pkg::tap_state_e state_q;
	jtag_pkg::tap_state_e state_d;

	////////////////////////////////////////
	// State register
	////////////////////////////////////////

	always_ff @(posedge dif)
	begin
		if (test_logic_reset)
			state_q <= jtag_pkg::ST_TLR;
		else
			state_q <= state_d;
	end

	////////////////////////////////////////
	// Next state from TMS
	////////////////////////////////////////

	always_comb
	begin
		case (state_q)
			jtag_pkg::ST_TLR:
				state_d = tms_i ? jtag_pkg::ST_TLR : jtag_pkg::ST_RTI;
			jtag_pkg::ST_RTI:
				state_d = tms_i ? jtag_pkg::ST_SEL_DR : jtag_pkg::ST_RTI;
			// DR column
			jtag_pkg::ST_SEL_DR:
				state_d = tms_i ? jtag_pkg::ST_SEL_IR : jtag_pkg::ST_CAP_DR;
			jtag_pkg::ST_CAP_DR:
				state_d = tms_i ? jtag_pkg::ST_EXIT1_DR : jtag_pkg::ST_SHIFT_DR;
			jtag_pkg::ST_SHIFT_DR:
				state_d = tms_i ? jtag_pkg::ST_EXIT1_DR : jtag_pkg::ST_SHIFT_DR;
			jtag_pkg::ST_EXIT1_DR:
				state_d = tms_i ? jtag_pkg::ST_UPD_DR : jtag_pkg::ST_PAUSE_DR;
			jtag_pkg::ST_PAUSE_DR:
				state_d = tms_i ? jtag_pkg::ST_EXIT2_DR : jtag_pkg::ST_PAUSE_DR;
			jtag_pkg::ST_EXIT2_DR:
				state_d = tms_i ? jtag_pkg::ST_UPD_DR : jtag_pkg::ST_SHIFT_DR;
			jtag_pkg::ST_UPD_DR:
				state_d = tms_i ? jtag_pkg::ST_SEL_DR : jtag_pkg::ST_RTI;
			// IR column
			// TMS high in Select-IR leaves for Test-Logic-Reset
			jtag_pkg::ST_SEL_IR:
				state_d = tms_i ? jtag_pkg::ST_TLR : jtag_pkg::ST_CAP_IR;
			jtag_pkg::ST_CAP_IR:
				state_d = tms_i ? jtag_pkg::ST_EXIT1_IR : jtag_pkg::ST_SHIFT_IR;
			jtag_pkg::ST_SHIFT_IR:
				state_d = tms_i ? jtag_pkg::ST_EXIT1_IR : jtag_pkg::ST_SHIFT_IR;
			jtag_pkg::ST_EXIT1_IR:
				state_d = tms_i ? jtag_pkg::ST_UPD_IR : jtag_pkg::ST_PAUSE_IR;
			jtag_pkg::ST_PAUSE_IR:
				state_d = tms_i ? jtag_pkg::ST_EXIT2_IR : jtag_pkg::ST_PAUSE_IR;
			jtag_pkg::ST_EXIT2_IR:
				state_d = tms_i ? jtag_pkg::ST_UPD_IR : jtag_pkg::ST_SHIFT_IR;
			jtag_pkg::ST_UPD_IR:
				state_d = tms_i ? jtag_pkg::ST_SEL_DR : jtag_pkg::ST_RTI;
			// Any unknown code falls back to reset
			default:
				state_d = jtag_pkg::ST_TLR;
		endcase
	end

	////////////////////////////////////////
	// State strobes
	////////////////////////////////////////

	// Decoded from the current state in the same cycle
	always_comb
	begin
		ctrl_o               = '0;
		ctrl_o.in_reset      = (state_q == jtag_pkg::ST_TLR);
		ctrl_o.run_test_idle = (state_q == jtag_pkg::ST_RTI);
		ctrl_o.capture_dr    = (state_q == jtag_pkg::ST_CAP_DR);
		ctrl_o.shift_dr      = (state_q == jtag_pkg::ST_SHIFT_DR);
		ctrl_o.pause_dr      = (state_q == jtag_pkg::ST_PAUSE_DR);
		ctrl_o.update_dr     = (state_q == jtag_pkg::ST_UPD_DR);
		ctrl_o.capture_ir    = (state_q == jtag_pkg::ST_CAP_IR);
		ctrl_o.shift_ir      = (state_q == jtag_pkg::ST_SHIFT_IR);
		ctrl_o.update_ir     = (state_q == jtag_pkg::ST_UPD_IR);
	end

endmodule

// File: hdl/jtag_pkg.sv
// JTAG TAP shared definitions
package jtag_pkg;

	////////////////////////////////////////
	// Widths
	////////////////////////////////////////

	// Instruction register length
	localparam int IR_W = 4;

	typedef logic [IR_W-1:0] ir_t;
	typedef logic [31:0]     idcode_t;

	////////////////////////////////////////
	// Instruction opcodes
	////////////////////////////////////////

	localparam ir_t OP_EXTEST         = 4'b0000;
	localparam ir_t OP_SAMPLE_PRELOAD = 4'b0001;
	localparam ir_t OP_IDCODE         = 4'b0010;
	localparam ir_t OP_DEBUG          = 4'b1000;
	localparam ir_t OP_MBIST          = 4'b1001;
	localparam ir_t OP_BYPASS         = 4'b1111;

	// Fixed pattern loaded in Capture-IR
	localparam ir_t IR_CAPTURE = 4'b0101;

	////////////////////////////////////////
	// TAP states
	////////////////////////////////////////

	// Binary encoding of the sixteen TAP states
	typedef enum logic [3:0] {
		ST_TLR       = 4'hF,
		ST_RTI       = 4'hC,
		ST_SEL_DR    = 4'h7,
		ST_CAP_DR    = 4'h6,
		ST_SHIFT_DR  = 4'h2,
		ST_EXIT1_DR  = 4'h1,
		ST_PAUSE_DR  = 4'h3,
		ST_EXIT2_DR  = 4'h0,
		ST_UPD_DR    = 4'h5,
		ST_SEL_IR    = 4'h4,
		ST_CAP_IR    = 4'hE,
		ST_SHIFT_IR  = 4'hA,
		ST_EXIT1_IR  = 4'h9,
		ST_PAUSE_IR  = 4'hB,
		ST_EXIT2_IR  = 4'h8,
		ST_UPD_IR    = 4'hD
	} tap_state_e;

	////////////////////////////////////////
	// Grouped signals
	////////////////////////////////////////

	// State strobes from the TAP FSM
	typedef struct packed {
		logic in_reset;
		logic run_test_idle;
		logic capture_dr;
		logic shift_dr;
		logic pause_dr;
		logic update_dr;
		logic capture_ir;
		logic shift_ir;
		logic update_ir;
	} tap_ctrl_t;

	// One-hot data register selects
	typedef struct packed {
		logic extest;
		logic sample_preload;
		logic idcode;
		logic mbist;
		logic debug;
		logic bypass;
	} dr_select_t;

	// Serial returns of the external chains
	typedef struct packed {
		logic bs_chain;
		logic mbist;
		logic debug;
	} chain_tdo_t;

endpackage
